// File: dcq_arbiter.sv
// dcq_arbiter fixed priority cache port select and queue pops
module dcq_arbiter
  import dcq_pkg::*;
(
  input  logic                   reply_insert,
  input  logic                   reply_exp,
  input  logic                   reply_second,
  input  logic [TAG_W-1:0]       reply_tag,
  input  logic [ADDR_W-1:0]      reply_exp_addr,
  input  logic [ADDR_W-1:0]      table_addr,
  input  logic                   table_dupl,
  input  logic                   dread_valid,
  input  logic [DREAD_ENT_W-1:0] dread_head,
  input  logic                   code_valid,
  input  logic [CODE_ENT_W-1:0]  code_head,
  output logic                   dread_pop,
  output logic                   code_pop,
  output logic                   cache_en,
  output logic                   cache_code,
  output logic                   cache_odd,
  output logic [TAG_W-1:0]       cache_req,
  output logic [LINE_W-1:0]      cache_line_addr,
  output logic                   cache_dupl,
  output logic                   cache_want_excl,
  output logic                   cache_ins_a,
  output logic                   cache_ins_b,
  output logic                   cache_exp
);

  logic [ADDR_W-1:0] dread_addr;
  logic [TAG_W-1:0]  dread_req;
  logic              dread_dupl;
  logic              dread_excl;
  logic [ADDR_W-1:0] code_addr;
  logic [TAG_W-1:0]  code_req;
  logic [ADDR_W-1:0] sel_addr;
  logic [TAG_W-1:0]  sel_req;
  logic              sel_dupl;
  logic              sel_excl;

  assign {dread_excl, dread_dupl, dread_req, dread_addr} = dread_head;
  assign {code_req, code_addr} = code_head;

  // replies first, then data reads, code reads last
  assign dread_pop = dread_valid && !reply_insert;
  assign code_pop  = code_valid && !reply_insert && !dread_valid;

  always_comb begin
    sel_addr = '0;
    sel_req  = '0;
    sel_dupl = 1'b0;
    sel_excl = 1'b0;
    if (reply_insert) begin
      sel_addr = reply_exp ? reply_exp_addr : table_addr;
      sel_req  = reply_tag;
      sel_dupl = !reply_exp && table_dupl;  // expunge carries no dupl
    end else if (dread_valid) begin
      sel_addr = dread_addr;
      sel_req  = dread_req;
      sel_dupl = dread_dupl;
      sel_excl = dread_excl;
    end else if (code_valid) begin
      sel_addr = code_addr;
      sel_req  = code_req;
    end
  end

  assign cache_en        = reply_insert || dread_pop || code_pop;
  assign cache_code      = code_pop;
  assign cache_odd       = sel_addr[0];
  assign cache_line_addr = sel_addr[ADDR_W-1:1];
  assign cache_req       = sel_req;
  assign cache_dupl      = sel_dupl;
  assign cache_want_excl = sel_excl;

  // line fill halves
  assign cache_ins_a = reply_insert && !reply_exp && !reply_second;
  assign cache_ins_b = reply_insert && !reply_exp && reply_second;
  assign cache_exp   = reply_insert && reply_exp;

endmodule

// File: dcq_checker.sv
// dcq_checker concurrent assertions on queue pushes, cache port flags and reset outputs
module dcq_checker (
  input logic clk,
  input logic rst,
  input logic dread_en,
  input logic dread_full,
  input logic code_en,
  input logic code_full,
  input logic miss_en,
  input logic miss_full,
  input logic rbus_want,
  input logic rbus_used,
  input logic cache_en,
  input logic cache_ins_a,
  input logic cache_ins_b,
  input logic cache_exp
);

  a_dread_room: assert property (@(posedge clk) disable iff (rst) dread_en |-> !dread_full)
    else $error("data read pushed into a full queue");
  a_code_room: assert property (@(posedge clk) disable iff (rst) code_en |-> !code_full)
    else $error("code read pushed into a full queue");
  a_miss_room: assert property (@(posedge clk) disable iff (rst) miss_en |-> !miss_full)
    else $error("miss pushed into a full queue");

  a_one_insert: assert property (@(posedge clk) disable iff (rst)
      $onehot0({cache_ins_a, cache_ins_b, cache_exp}))
    else $error("more than one insert kind on the cache port");

  a_used_wants: assert property (@(posedge clk) disable iff (rst) rbus_used |-> rbus_want)
    else $error("ring bus send without a pending request");

  // outputs settle one edge into reset
  a_reset_quiet: assert property (@(posedge clk) rst && $past(rst) |->
      !(cache_en || rbus_want || rbus_used || cache_ins_a || cache_ins_b || cache_exp))
    else $error("control output active during reset");

endmodule

bind dcq_top dcq_checker u_checker (
  .clk(clk), .rst(rst), .dread_en(dread_en), .dread_full(u_dread.full),
  .code_en(code_en), .code_full(u_code.full), .miss_en(miss_en),
  .miss_full(u_miss.u_fifo.full), .rbus_want(rbus_want), .rbus_used(rbus_used),
  .cache_en(cache_en), .cache_ins_a(cache_ins_a), .cache_ins_b(cache_ins_b),
  .cache_exp(cache_exp)
);

// File: dcq_fifo.sv
// dcq_fifo circular request queue with occupancy count
module dcq_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head,
  output logic             not_empty,
  output logic             full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // wraps at DEPTH, not at a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head      = mem[rd_ptr];  // combinational from storage
  assign not_empty = (count != '0);
  assign full      = (count == CNT_W'(DEPTH));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: dcq_miss_issue.sv
// dcq_miss_issue miss queue and its drain onto the ring bus
module dcq_miss_issue
  import dcq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 miss_en,
  input  logic [ADDR_W-1:0]    miss_addr,
  input  logic [TAG_W-1:0]     miss_req,
  input  logic                 miss_dupl,
  input  logic                 miss_want_excl,
  input  logic                 rbus_can,
  output logic                 rbus_want,
  output logic                 rbus_used,
  output logic [ADDR_W-1:0]    rbus_addr,
  output logic [BUS_REQ_W-1:0] rbus_src_req,
  output logic                 rbus_code,
  output logic                 rbus_dupl,
  output logic                 rbus_want_excl
);

  logic [MISS_ENT_W-1:0] miss_head;
  logic [TAG_W-1:0]      head_req;
  logic                  miss_pending;

  dcq_fifo #(
    .DEPTH(MISS_DEPTH),
    .WIDTH(MISS_ENT_W)
  ) u_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (miss_en),
    .push_data({miss_want_excl, miss_dupl, miss_req, miss_addr}),
    .pop      (rbus_used),
    .head     (miss_head),
    .not_empty(miss_pending),
    .full     ()
  );

  assign {rbus_want_excl, rbus_dupl, head_req, rbus_addr} = miss_head;

  assign rbus_want = miss_pending;  // level, held until granted
  assign rbus_used = rbus_can && rbus_want;  // head leaves this cycle

  assign rbus_src_req = {CACHE_ID, head_req};
  assign rbus_code    = (head_req[TAG_W-1:TAG_W-2] == CODE_REQ_MARK);

endmodule

// File: dcq_pkg.sv
// shared widths, queue depths, entry layouts and ring identifier
package dcq_pkg;

  // line address with the odd bank bit in position 0
  localparam int ADDR_W = 37;
  localparam int LINE_W = 36;  // address without the odd bit

  // request tags
  localparam int TAG_W     = 5;
  localparam int TAG_COUNT = 32;

  // ring bus requester field is identifier then tag
  localparam int BUS_REQ_W = 10;
  localparam logic [BUS_REQ_W-TAG_W-1:0] CACHE_ID = 5'd0;

  // queue depths
  localparam int DREAD_DEPTH = 21;
  localparam int CODE_DEPTH  = 8;
  localparam int MISS_DEPTH  = 28;

  // top two tag bits of a code request
  localparam logic [1:0] CODE_REQ_MARK = 2'b10;

  // data read entry {want_excl, dupl, req, addr}
  localparam int DREAD_ENT_W = ADDR_W + TAG_W + 2;

  // code read entry {req, addr}
  localparam int CODE_ENT_W = ADDR_W + TAG_W;

  // miss entry {want_excl, dupl, req, addr}
  localparam int MISS_ENT_W = ADDR_W + TAG_W + 2;

endpackage

// File: dcq_reply_stage.sv
// dcq_reply_stage registered ring bus reply decode
module dcq_reply_stage
  import dcq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rbusan_used,
  input  logic                 rbusan_mem_reply,
  input  logic                 rbusan_expun,
  input  logic                 rbusan_second,
  input  logic [BUS_REQ_W-1:0] rbusan_dst_req,
  input  logic [63:0]          rbusan_data64,
  output logic                 reply_insert,
  output logic                 reply_exp,
  output logic                 reply_second,
  output logic [TAG_W-1:0]     reply_tag,
  output logic [ADDR_W-1:0]    reply_exp_addr
);

  logic for_us;
  logic is_exp;

  assign for_us = rbusan_mem_reply && (rbusan_dst_req[BUS_REQ_W-1:TAG_W] == CACHE_ID);
  assign is_exp = rbusan_used && rbusan_expun;

  always_ff @(posedge clk) begin
    if (rst) begin
      reply_insert <= 1'b0;
      reply_exp    <= 1'b0;
    end else begin
      reply_insert <= (rbusan_used && for_us) || is_exp;
      reply_exp    <= is_exp;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    reply_second   <= rbusan_second;
    reply_tag      <= rbusan_dst_req[TAG_W-1:0];
    reply_exp_addr <= rbusan_data64[ADDR_W-1:0];  // expunge line address
  end

endmodule

// File: dcq_reply_table.sv
// dcq_reply_table miss address store indexed by tag with post-reset clear sweep
module dcq_reply_table
  import dcq_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              miss_en,
  input  logic [TAG_W-1:0]  miss_req,
  input  logic [ADDR_W-1:0] miss_addr,
  input  logic              miss_dupl,
  input  logic [TAG_W-1:0]  rd_tag,
  output logic [ADDR_W-1:0] rd_addr,
  output logic              rd_dupl
);

  // each entry is {dupl, addr}
  logic [ADDR_W:0]  entry_mem [TAG_COUNT];
  logic             sweep_on;
  logic [TAG_W-1:0] sweep_cnt;

  // rd_tag comes already registered from the reply stage
  assign {rd_dupl, rd_addr} = entry_mem[rd_tag];

  always_ff @(posedge clk) begin
    if (sweep_on) begin
      entry_mem[sweep_cnt] <= '0;
    end else if (miss_en) begin
      entry_mem[miss_req] <= {miss_dupl, miss_addr};
    end
  end

  // one entry cleared per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_on  <= 1'b1;
      sweep_cnt <= '0;
    end else if (sweep_on) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == TAG_W'(TAG_COUNT - 1)) begin
        sweep_on <= 1'b0;  // last entry done
      end
    end
  end

endmodule

// File: dcq_top.sv
// dcq_top data cache request side top level
module dcq_top
  import dcq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 dread_en,
  input  logic [ADDR_W-1:0]    dread_addr,
  input  logic [TAG_W-1:0]     dread_req,
  input  logic                 dread_dupl,
  input  logic                 dread_want_excl,
  input  logic                 code_en,
  input  logic [ADDR_W-1:0]    code_addr,
  input  logic [TAG_W-1:0]     code_req,
  input  logic                 miss_en,
  input  logic [ADDR_W-1:0]    miss_addr,
  input  logic [TAG_W-1:0]     miss_req,
  input  logic                 miss_dupl,
  input  logic                 miss_want_excl,
  input  logic                 rbus_can,
  input  logic                 rbusan_used,
  input  logic                 rbusan_mem_reply,
  input  logic                 rbusan_expun,
  input  logic                 rbusan_second,
  input  logic [BUS_REQ_W-1:0] rbusan_dst_req,
  input  logic [63:0]          rbusan_data64,
  output logic                 rbus_want,
  output logic                 rbus_used,
  output logic [ADDR_W-1:0]    rbus_addr,
  output logic [BUS_REQ_W-1:0] rbus_src_req,
  output logic                 rbus_code,
  output logic                 rbus_dupl,
  output logic                 rbus_want_excl,
  output logic                 cache_en,
  output logic                 cache_code,
  output logic                 cache_odd,
  output logic [TAG_W-1:0]     cache_req,
  output logic [LINE_W-1:0]    cache_line_addr,
  output logic                 cache_dupl,
  output logic                 cache_want_excl,
  output logic                 cache_ins_a,
  output logic                 cache_ins_b,
  output logic                 cache_exp
);

  logic [DREAD_ENT_W-1:0] dread_head;
  logic [CODE_ENT_W-1:0]  code_head;
  logic                   dread_valid, dread_pop;
  logic                   code_valid, code_pop;
  logic                   reply_insert, reply_exp, reply_second;
  logic [TAG_W-1:0]       reply_tag;
  logic [ADDR_W-1:0]      reply_exp_addr;
  logic [ADDR_W-1:0]      table_addr;
  logic                   table_dupl;

  dcq_fifo #(.DEPTH(DREAD_DEPTH), .WIDTH(DREAD_ENT_W)) u_dread (
    .clk(clk), .rst(rst), .push(dread_en),
    .push_data({dread_want_excl, dread_dupl, dread_req, dread_addr}),
    .pop(dread_pop), .head(dread_head), .not_empty(dread_valid), .full()
  );

  dcq_fifo #(.DEPTH(CODE_DEPTH), .WIDTH(CODE_ENT_W)) u_code (
    .clk(clk), .rst(rst), .push(code_en), .push_data({code_req, code_addr}),
    .pop(code_pop), .head(code_head), .not_empty(code_valid), .full()
  );

  dcq_reply_table u_table (
    .clk(clk), .rst(rst), .miss_en(miss_en), .miss_req(miss_req),
    .miss_addr(miss_addr), .miss_dupl(miss_dupl), .rd_tag(reply_tag),
    .rd_addr(table_addr), .rd_dupl(table_dupl)
  );

  dcq_reply_stage u_reply (
    .clk(clk), .rst(rst), .rbusan_used(rbusan_used), .rbusan_mem_reply(rbusan_mem_reply),
    .rbusan_expun(rbusan_expun), .rbusan_second(rbusan_second),
    .rbusan_dst_req(rbusan_dst_req), .rbusan_data64(rbusan_data64),
    .reply_insert(reply_insert), .reply_exp(reply_exp), .reply_second(reply_second),
    .reply_tag(reply_tag), .reply_exp_addr(reply_exp_addr)
  );

  dcq_arbiter u_arb (
    .reply_insert(reply_insert), .reply_exp(reply_exp), .reply_second(reply_second),
    .reply_tag(reply_tag), .reply_exp_addr(reply_exp_addr), .table_addr(table_addr),
    .table_dupl(table_dupl), .dread_valid(dread_valid), .dread_head(dread_head),
    .code_valid(code_valid), .code_head(code_head), .dread_pop(dread_pop),
    .code_pop(code_pop), .cache_en(cache_en), .cache_code(cache_code),
    .cache_odd(cache_odd), .cache_req(cache_req), .cache_line_addr(cache_line_addr),
    .cache_dupl(cache_dupl), .cache_want_excl(cache_want_excl),
    .cache_ins_a(cache_ins_a), .cache_ins_b(cache_ins_b), .cache_exp(cache_exp)
  );

  dcq_miss_issue u_miss (
    .clk(clk), .rst(rst), .miss_en(miss_en), .miss_addr(miss_addr),
    .miss_req(miss_req), .miss_dupl(miss_dupl), .miss_want_excl(miss_want_excl),
    .rbus_can(rbus_can), .rbus_want(rbus_want), .rbus_used(rbus_used),
    .rbus_addr(rbus_addr), .rbus_src_req(rbus_src_req), .rbus_code(rbus_code),
    .rbus_dupl(rbus_dupl), .rbus_want_excl(rbus_want_excl)
  );

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --assert --top-module tb_top -f src.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1 || true
cat sim.log
! grep -q -e "Test FAILED" -e "%Error" sim.log && grep -q "Test OK" sim.log

// File: src.f
dcq_pkg.sv
dcq_fifo.sv
dcq_reply_table.sv
dcq_reply_stage.sv
dcq_arbiter.sv
dcq_miss_issue.sv
dcq_top.sv
tb_clock.sv
dcq_checker.sv
tb_top.sv

// File: tb_clock.sv
// tb_clock testbench clock and reset generator
module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;  // released on a rising edge
  end

endmodule

// File: tb_top.sv
// tb_top testbench with stimulus, reference model, compare process and reporting
module tb_top
  import dcq_pkg::*;
();

  localparam int M_IDLE  = 0;
  localparam int M_DREAD = 1;
  localparam int M_MIXED = 2;
  localparam int M_MISS  = 3;
  localparam int M_REPLY = 4;
  localparam int M_EXPUN = 5;
  localparam int DRAIN = 60;  // longer than the deepest queue
  localparam int RUN_CYCLES = 20 + 200 + 300 + 300 + 300 + 150 + 6 * DRAIN;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + 8 + TAG_COUNT + 200;
  localparam int ENT_W = ADDR_W + TAG_W + 2;

  logic clk, rst;
  logic dread_en, dread_dupl, dread_want_excl, code_en, miss_en, miss_dupl, miss_want_excl;
  logic rbus_can, rbusan_used, rbusan_mem_reply, rbusan_expun, rbusan_second;
  logic [ADDR_W-1:0] dread_addr, code_addr, miss_addr, rbus_addr;
  logic [TAG_W-1:0] dread_req, code_req, miss_req, cache_req;
  logic [BUS_REQ_W-1:0] rbusan_dst_req, rbus_src_req;
  logic [63:0] rbusan_data64;
  logic rbus_want, rbus_used, rbus_code, rbus_dupl, rbus_want_excl;
  logic cache_en, cache_code, cache_odd, cache_dupl, cache_want_excl;
  logic cache_ins_a, cache_ins_b, cache_exp;
  logic [LINE_W-1:0] cache_line_addr;

  // model state, entries are {addr, req, dupl, excl}
  logic [ENT_W-1:0] dq [$];
  logic [ADDR_W+TAG_W-1:0] cq [$];
  logic [ENT_W-1:0] mq [$];
  logic [ADDR_W:0] tbl_model [TAG_COUNT];  // {dupl, addr}
  logic m_ins, m_exp, m_second;
  logic [TAG_W-1:0] m_tag;
  logic [ADDR_W-1:0] m_exp_addr;
  logic [48:0] exp_cache;
  logic [51:0] exp_rbus;
  logic [31:0] seed = 32'hfc60_216d;
  int checks = 0;
  int errors = 0;
  int tests = 0;

  tb_clock u_clock (.clk(clk), .rst(rst));

  dcq_top u_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic logic [ADDR_W-1:0] rand_addr();
    logic [63:0] w;
    w = {next_rand(), next_rand()};
    return w[ADDR_W-1:0];
  endfunction

  // {en, code, ins_a, ins_b, exp, odd, req, line, dupl, excl}
  function automatic logic [48:0] ref_cache();
    logic [ADDR_W-1:0] a;
    logic [TAG_W-1:0] t;
    logic d;
    logic x;
    if (m_ins) begin
      a = m_exp ? m_exp_addr : tbl_model[m_tag][ADDR_W-1:0];
      d = !m_exp && tbl_model[m_tag][ADDR_W];
      return {1'b1, 1'b0, !m_exp && !m_second, !m_exp && m_second, m_exp,
              a[0], m_tag, a[ADDR_W-1:1], d, 1'b0};
    end
    if (dq.size() > 0) begin
      {a, t, d, x} = dq[0];
      return {5'b10000, a[0], t, a[ADDR_W-1:1], d, x};
    end
    if (cq.size() > 0) begin
      {a, t} = cq[0];
      return {5'b11000, a[0], t, a[ADDR_W-1:1], 2'b00};
    end
    return '0;
  endfunction

  // {want, used, addr, src_req, code, dupl, excl}
  function automatic logic [51:0] ref_rbus(input logic can);
    logic [ADDR_W-1:0] a;
    logic [TAG_W-1:0] t;
    logic d;
    logic x;
    if (mq.size() == 0) return '0;
    {a, t, d, x} = mq[0];
    return {1'b1, can, a, CACHE_ID, t, t[TAG_W-1:TAG_W-2] == CODE_REQ_MARK, d, x};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  // state after the coming edge, from the inputs now applied
  task automatic advance_model();
    if (!m_ins && dq.size() > 0) begin
      void'(dq.pop_front());
    end else if (!m_ins && cq.size() > 0) begin
      void'(cq.pop_front());
    end
    if (rbus_can && mq.size() > 0) void'(mq.pop_front());
    if (dread_en) dq.push_back({dread_addr, dread_req, dread_dupl, dread_want_excl});
    if (code_en) cq.push_back({code_addr, code_req});
    if (miss_en) begin
      mq.push_back({miss_addr, miss_req, miss_dupl, miss_want_excl});
      tbl_model[miss_req] = {miss_dupl, miss_addr};
    end
    m_exp = rbusan_used && rbusan_expun;
    m_ins = m_exp || (rbusan_used && rbusan_mem_reply &&
                      rbusan_dst_req[BUS_REQ_W-1:TAG_W] == CACHE_ID);
    m_second = rbusan_second;
    m_tag = rbusan_dst_req[TAG_W-1:0];
    m_exp_addr = rbusan_data64[ADDR_W-1:0];
  endtask

  // compare mid cycle where outputs are settled
  always @(negedge clk) begin
    if (rst !== 1'b0) begin
      dq.delete();
      cq.delete();
      mq.delete();
      m_ins = 1'b0;
      m_exp = 1'b0;
    end else begin
      exp_cache = ref_cache();
      exp_rbus = ref_rbus(rbus_can);
      check_value("cache_ctrl", 64'({cache_en, cache_code, cache_ins_a, cache_ins_b,
                  cache_exp}), 64'(exp_cache[48:44]));
      if (exp_cache[48])
        check_value("cache_data", 64'({cache_odd, cache_req, cache_line_addr, cache_dupl,
                    cache_want_excl}), 64'(exp_cache[43:0]));
      check_value("rbus_ctrl", 64'({rbus_want, rbus_used}), 64'(exp_rbus[51:50]));
      if (exp_rbus[51])
        check_value("rbus_data", 64'({rbus_addr, rbus_src_req, rbus_code, rbus_dupl,
                    rbus_want_excl}), 64'(exp_rbus[49:0]));
      advance_model();
    end
  end

  task automatic drive_cycle(input int mode);
    logic [31:0] r;
    logic [31:0] s;
    r = next_rand();
    s = next_rand();
    dread_en <= mode != M_IDLE && mode != M_MISS && r[0] && dq.size() < DREAD_DEPTH;
    dread_addr <= rand_addr();
    dread_req <= r[12:8];
    dread_dupl <= r[13];
    dread_want_excl <= r[14];
    code_en <= (mode == M_MIXED || (mode == M_REPLY && r[1])) && r[2] &&
               cq.size() < CODE_DEPTH;
    code_addr <= rand_addr();
    code_req <= r[19:15];
    miss_en <= (mode == M_MISS || mode == M_REPLY) && r[3] && mq.size() < MISS_DEPTH;
    miss_addr <= rand_addr();
    miss_req <= r[24:20];
    miss_dupl <= r[25];
    miss_want_excl <= r[26];
    rbus_can <= (mode == M_MISS || mode == M_REPLY) ? r[27] : 1'b1;
    rbusan_used <= (mode == M_REPLY || mode == M_EXPUN) && r[4] && r[5];
    rbusan_mem_reply <= (mode == M_REPLY) || s[0];
    rbusan_expun <= (mode == M_EXPUN) && s[1];
    rbusan_second <= s[2];
    rbusan_dst_req <= {s[3] ? CACHE_ID : s[8:4], s[13:9]};  // half aimed at us
    rbusan_data64 <= {next_rand(), s};
  endtask

  task automatic run_test(input string name, input int mode, input int cycles);
    int err0;
    err0 = errors;
    repeat (cycles) begin
      @(posedge clk);
      drive_cycle(mode);
    end
    repeat (DRAIN) begin
      @(posedge clk);
      drive_cycle(M_IDLE);
    end
    tests++;
    $display("test %0d %s: %0d cycles, %0d errors", tests, name, cycles, errors - err0);
  endtask

  initial begin
    foreach (tbl_model[i]) tbl_model[i] = '0;
    drive_cycle(M_IDLE);
    @(negedge rst);
    repeat (TAG_COUNT + 2) @(posedge clk);  // tag table clear sweep
    run_test("reset idle", M_IDLE, 20);
    run_test("data reads", M_DREAD, 200);
    run_test("data and code reads", M_MIXED, 300);
    run_test("misses", M_MISS, 300);
    run_test("mem replies", M_REPLY, 300);
    run_test("expunges", M_EXPUN, 150);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule
